// File: all.f
verilog/lpif_pkg.sv
verilog/ll_auto_sync.sv
verilog/lpif_user_if.sv
verilog/lpif_phy_concat.sv
verilog/lpif_link_top.sv
dv/lpif_link_props.sv
dv/lpif_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lpif_link_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/lpif_link_tb.sv
`timescale 1ns/1ps

module lpif_link_tb
  import lpif_pkg::*;
();

  localparam int n_beats    = 12;
  localparam int wait_limit = 64;

  // Per-beat valids and dvalids
  // Random fields fill the rest of the beat
  typedef struct packed {
    logic [1:0] valid;
    logic [1:0] dvalid;
  } stim_t;

  // Nine entries with nonzero valid
  localparam stim_t stim_tbl [n_beats] = '{
    '{2'b01, 2'b01}, '{2'b11, 2'b11}, '{2'b00, 2'b00},
    '{2'b10, 2'b10}, '{2'b11, 2'b01}, '{2'b00, 2'b11},
    '{2'b01, 2'b00}, '{2'b11, 2'b11}, '{2'b00, 2'b00},
    '{2'b10, 2'b11}, '{2'b11, 2'b10}, '{2'b01, 2'b01}
  };

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic [delay_width-1:0]  delay_x_value;
  logic [delay_width-1:0]  delay_y_value;
  logic [delay_width-1:0]  delay_z_value;
  logic [marker_width-1:0] tx_mrk_userbit;
  logic                    tx_stb_userbit;
  lpif_beat_t              dstrm;
  lpif_beat_t              ustrm;
  phy_chan_t               rx_phy0;
  phy_chan_t               rx_phy1;
  phy_chan_t               tx_phy0;
  phy_chan_t               tx_phy1;
  logic [31:0]             tx_downstream_debug_status;
  logic [31:0]             rx_upstream_debug_status;

  int          chk_cnt;
  int          err_cnt;
  int          test_base;
  logic [31:0] rng;
  // Beats in flight with the oldest first
  lpif_beat_t  exp_q [$];

  lpif_link_top UUT (.*);

  // External PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  //////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random payload fields around the table valids
  task automatic build_beat(input logic [1:0] valid, input logic [1:0] dvalid,
                            output lpif_beat_t beat);
    int w;
    beat = '0;
    rng = xorshift32(rng);
    beat.state  = rng[7:0];
    beat.protid = rng[11:8];
    beat.crc    = rng[15:12];
    for (w = 0; w < 4; w++) begin
      rng = xorshift32(rng);
      beat.data[w*32 +: 32] = rng;
    end
    beat.valid     = valid;
    beat.dvalid    = dvalid;
    beat.crc_valid = valid;
  endtask

  // Expected online channel word
  // Low half of the beat rides on channel 0
  function automatic phy_chan_t expect_chan(input lpif_beat_t beat, input int idx,
                                            input logic strobe);
    logic [beat_width-1:0] bits;
    phy_chan_t             chan;
    bits = beat;
    chan = '0;
    chan.marker = 1'b1;
    chan.strobe = strobe;
    if (idx == 0) begin
      chan.payload = bits[chan_payload-1:0];
    end else begin
      chan.payload = bits[beat_width-1:chan_payload];
    end
    return chan;
  endfunction

  // Debug status word layout
  function automatic logic [31:0] status_word(input logic tx_on, input logic rx_on,
                                              input logic [15:0] count);
    logic [31:0] word;
    word = '0;
    // Online flags
    word[19] = tx_on;
    word[18] = rx_on;
    // Valid beat count
    word[15:0] = count;
    return word;
  endfunction

  //////////////////////////////////////////////////
  // Compare and report
  //////////////////////////////////////////////////

  task automatic check_beat(input string name, input lpif_beat_t got, input lpif_beat_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_phy(input string name, input phy_chan_t got, input phy_chan_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  // Cycle distances between events
  task automatic check_count(input string name, input int got, input int exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic close_test(input string name);
    int fails;
    fails     = err_cnt - test_base;
    test_base = err_cnt;
    if (fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed, %0d mismatches", name, fails);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  // Idle link with clear counters and online bits
  task automatic check_idle_outputs();
    check_beat("ustrm", ustrm, '0);
    check_phy("tx_phy0", tx_phy0, '0);
    check_phy("tx_phy1", tx_phy1, '0);
    check_status("tx_downstream_debug_status", tx_downstream_debug_status, '0);
    check_status("rx_upstream_debug_status", rx_upstream_debug_status, '0);
  endtask

  // Edges from the caller's edge until a status bit reads high
  task automatic count_edges_to_status(input int bit_idx, output int edges);
    edges = 0;
    do begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      edges++;
    end while (!tx_downstream_debug_status[bit_idx] && edges < wait_limit);
    if (!tx_downstream_debug_status[bit_idx]) begin
      abort_on_timeout($sformatf("status bit %0d never rose", bit_idx));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int         edges;
    int         valid_cnt;
    lpif_beat_t beat;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 16'd3;
    delay_y_value  = 16'd4;
    delay_z_value  = 16'd5;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    dstrm          = '0;
    rng            = 32'hc5f7_c662;
    chk_cnt        = 0;
    err_cnt        = 0;
    test_base      = 0;

    // Reset held for 8 edges and two idle cycles after it
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_wr);
      if (i == 7) begin
        rst_n <= 1'b1;
      end
      @(negedge clk_wr);
      check_idle_outputs();
    end
    repeat (2) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      check_idle_outputs();
    end
    close_test("reset");

    // Changing beats and user bits while offline
    // Zero valid keeps the counters at zero
    for (int i = 0; i < 6; i++) begin
      build_beat(2'b00, 2'b11, beat);
      @(posedge clk_wr);
      dstrm          <= beat;
      tx_mrk_userbit <= 2'b11;
      tx_stb_userbit <= 1'b1;
      @(negedge clk_wr);
      check_idle_outputs();
    end
    close_test("offline gating");

    // Link up
    // One edge samples each input before the delay starts
    @(posedge clk_wr);
    dstrm          <= '0;
    tx_mrk_userbit <= '0;
    tx_stb_userbit <= 1'b0;
    tx_online      <= 1'b1;
    rx_online      <= 1'b1;
    count_edges_to_status(18, edges);
    check_count("rx_online_delay edges", edges, 1 + int'(delay_x_value));
    check_status("tx_downstream_debug_status", tx_downstream_debug_status,
                 status_word(1'b0, 1'b1, 16'h0000));
    check_status("rx_upstream_debug_status", rx_upstream_debug_status,
                 status_word(1'b0, 1'b1, 16'h0000));
    count_edges_to_status(19, edges);
    check_count("tx_online_delay edges", edges, 1 + int'(delay_y_value));
    check_status("tx_downstream_debug_status", tx_downstream_debug_status,
                 status_word(1'b1, 1'b1, 16'h0000));
    check_status("rx_upstream_debug_status", rx_upstream_debug_status,
                 status_word(1'b1, 1'b1, 16'h0000));
    close_test("online timing");

    // Marker on the first framed word and strobe delay_z later
    // Framing register adds one edge to both
    edges = 0;
    do begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      edges++;
      if (!tx_phy0.strobe) begin
        check_phy("tx_phy0", tx_phy0, expect_chan('0, 0, 1'b0));
        check_phy("tx_phy1", tx_phy1, expect_chan('0, 1, 1'b0));
      end
    end while (!tx_phy0.strobe && edges < wait_limit);
    if (!tx_phy0.strobe) begin
      abort_on_timeout("strobe never rose on tx_phy0");
    end
    check_count("tx_phy strobe edges", edges, 1 + int'(delay_z_value));
    check_phy("tx_phy0", tx_phy0, expect_chan('0, 0, 1'b1));
    check_phy("tx_phy1", tx_phy1, expect_chan('0, 1, 1'b1));
    close_test("marker and strobe");

    // Table beats followed by three idle beats to drain the pipe
    valid_cnt = 0;
    exp_q     = {};
    repeat (3) exp_q.push_back('0);
    for (int c = 0; c < n_beats + 3; c++) begin
      beat = '0;
      if (c < n_beats) begin
        build_beat(stim_tbl[c].valid, stim_tbl[c].dvalid, beat);
        if (stim_tbl[c].valid != 2'b00) begin
          valid_cnt++;
        end
      end
      @(posedge clk_wr);
      dstrm <= beat;
      @(negedge clk_wr);
      // ustrm lags three beats and tx_phy two
      check_beat("ustrm", ustrm, exp_q[0]);
      check_phy("tx_phy0", tx_phy0, expect_chan(exp_q[1], 0, 1'b1));
      check_phy("tx_phy1", tx_phy1, expect_chan(exp_q[1], 1, 1'b1));
      void'(exp_q.pop_front());
      exp_q.push_back(beat);
    end
    close_test("beat stream");

    // Rx counter samples ustrm one edge later
    repeat (2) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
    end
    check_status("tx_downstream_debug_status", tx_downstream_debug_status,
                 status_word(1'b1, 1'b1, 16'(valid_cnt)));
    check_status("rx_upstream_debug_status", rx_upstream_debug_status,
                 status_word(1'b1, 1'b1, 16'(valid_cnt)));
    close_test("beat counters");

    $display("summary: %0d checks, %0d mismatches", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: dv/lpif_link_props.sv
`timescale 1ns/1ps

module lpif_link_props
  import lpif_pkg::*;
(
  input logic      clk_wr,
  input logic      rst_n,
  input logic      tx_online_delay,
  input logic      rx_online_delay,
  input phy_chan_t tx_phy0,
  input phy_chan_t tx_phy1
);

  //////////////////////////////////////////////////
  // Reset and online ordering
  //////////////////////////////////////////////////

  // Any reset cycle leaves both channels cleared
  reset_clears_phy: assert property (@(posedge clk_wr)
    !rst_n |=> (tx_phy0 == '0 && tx_phy1 == '0))
    else $error("tx_phy not zero after a reset cycle");

  // Tx side comes up only behind rx side
  tx_after_rx: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_online_delay) |-> rx_online_delay)
    else $error("tx_online_delay rose while rx_online_delay low");

  //////////////////////////////////////////////////
  // Framing
  //////////////////////////////////////////////////

  // Top three bits of each channel
  spare_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (tx_phy0.spare == '0 && tx_phy1.spare == '0))
    else $error("spare bits set on tx_phy");

  // Offline framing register loads all zeros
  offline_gates_phy: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |=> (tx_phy0 == '0 && tx_phy1 == '0))
    else $error("tx_phy not zero while offline");

endmodule

bind lpif_link_top lpif_link_props u_props (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1)
);

// File: verilog/lpif_link_top.sv
`timescale 1ns/1ps

module lpif_link_top
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,
  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [delay_width-1:0]  delay_x_value,
  input  logic [delay_width-1:0]  delay_y_value,
  input  logic [delay_width-1:0]  delay_z_value,
  input  logic [marker_width-1:0] tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  // User side
  input  lpif_beat_t              dstrm,
  output lpif_beat_t              ustrm,
  // PHY side
  input  phy_chan_t               rx_phy0,
  input  phy_chan_t               rx_phy1,
  output phy_chan_t               tx_phy0,
  output phy_chan_t               tx_phy1,
  // Debug
  output logic [31:0]             tx_downstream_debug_status,
  output logic [31:0]             rx_upstream_debug_status
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  lpif_beat_t              txfifo_downstream_data;
  lpif_beat_t              rx_upstream_data;
  logic                    tx_online_delay;
  logic                    rx_online_delay;
  logic [marker_width-1:0] tx_auto_mrk_userbit;
  logic                    tx_auto_stb_userbit;

  // Online sequencing
  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  // Beat register and status
  lpif_user_if u_user_if (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .dstrm                      (dstrm),
    .ustrm                      (ustrm),
    .txfifo_downstream_data     (txfifo_downstream_data),
    .rx_upstream_data           (rx_upstream_data),
    .tx_online_delay            (tx_online_delay),
    .rx_online_delay            (rx_online_delay),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  // Two-channel framing, gated by delayed tx online
  lpif_phy_concat u_phy_concat (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_downstream_data (txfifo_downstream_data),
    .rx_upstream_data   (rx_upstream_data),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .tx_online          (tx_online_delay),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_stb_userbit     (tx_auto_stb_userbit)
  );

endmodule

// File: verilog/lpif_phy_concat.sv
`timescale 1ns/1ps

module lpif_phy_concat
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  lpif_beat_t              tx_downstream_data,
  output lpif_beat_t              rx_upstream_data,
  output phy_chan_t               tx_phy0,
  output phy_chan_t               tx_phy1,
  input  phy_chan_t               rx_phy0,
  input  phy_chan_t               rx_phy1,
  input  logic                    tx_online,
  input  logic [marker_width-1:0] tx_mrk_userbit,
  input  logic                    tx_stb_userbit
);

  //////////////////////////////////////////////////
  // Transmit framing
  //////////////////////////////////////////////////

  // Build one channel word, all zero while offline
  function automatic phy_chan_t frame_chan(
    input logic [chan_payload-1:0] payload,
    input logic                    marker,
    input logic                    strobe,
    input logic                    online
  );
    phy_chan_t chan;
    chan = '0;
    if (online) begin
      chan.marker  = marker;
      chan.strobe  = strobe;
      chan.payload = payload;
    end
    return chan;
  endfunction

  phy_chan_t tx_phy0_nxt;
  phy_chan_t tx_phy1_nxt;

  // Low half of the beat on channel 0
  assign tx_phy0_nxt = frame_chan(tx_downstream_data[chan_payload-1:0],
                                  tx_mrk_userbit[0], tx_stb_userbit, tx_online);

  // High half on channel 1
  assign tx_phy1_nxt = frame_chan(tx_downstream_data[beat_width-1 -: chan_payload],
                                  tx_mrk_userbit[1], tx_stb_userbit, tx_online);

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx_phy0_nxt;
      tx_phy1 <= tx_phy1_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Receive reassembly
  //////////////////////////////////////////////////

  // Markers and strobes are dropped here
  lpif_beat_t rx_beat_nxt;

  assign rx_beat_nxt = lpif_beat_t'({rx_phy1.payload, rx_phy0.payload});

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_upstream_data <= '0;
    end else begin
      rx_upstream_data <= rx_beat_nxt;
    end
  end

endmodule

// File: verilog/lpif_user_if.sv
`timescale 1ns/1ps

module lpif_user_if
  import lpif_pkg::*;
(
  input  logic        clk_wr,
  input  logic        rst_n,
  input  lpif_beat_t  dstrm,
  output lpif_beat_t  ustrm,
  output lpif_beat_t  txfifo_downstream_data,
  input  lpif_beat_t  rx_upstream_data,
  input  logic        tx_online_delay,
  input  logic        rx_online_delay,
  output logic [31:0] tx_downstream_debug_status,
  output logic [31:0] rx_upstream_debug_status
);

  //////////////////////////////////////////////////
  // Downstream beat
  //////////////////////////////////////////////////

  // Every beat accepted, no back-pressure
  always_ff @(posedge clk_wr) begin
    txfifo_downstream_data <= dstrm;
  end

  // Valid beats taken in, counted on the same edge
  logic [15:0] tx_beat_cnt;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_beat_cnt <= '0;
    end else if (dstrm.valid != '0) begin
      // Wraps at 16 bits
      tx_beat_cnt <= tx_beat_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Upstream beat
  //////////////////////////////////////////////////

  // Already registered in the framing block
  assign ustrm = rx_upstream_data;

  logic [15:0] rx_beat_cnt;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_beat_cnt <= '0;
    end else if (rx_upstream_data.valid != '0) begin
      rx_beat_cnt <= rx_beat_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Debug status
  //////////////////////////////////////////////////

  // Layout
  //   19    tx online
  //   18    rx online
  //   15:0  valid beat count
  assign tx_downstream_debug_status = {
    12'h000,
    tx_online_delay,
    rx_online_delay,
    2'b00,
    tx_beat_cnt
  };

  assign rx_upstream_debug_status = {
    12'h000,
    tx_online_delay,
    rx_online_delay,
    2'b00,
    rx_beat_cnt
  };

endmodule

// File: verilog/ll_auto_sync.sv
`timescale 1ns/1ps

module ll_auto_sync
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [delay_width-1:0]  delay_x_value,
  input  logic [delay_width-1:0]  delay_y_value,
  input  logic [delay_width-1:0]  delay_z_value,
  input  logic [marker_width-1:0] tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  output logic                    tx_online_delay,
  output logic                    rx_online_delay,
  output logic [marker_width-1:0] tx_auto_mrk_userbit,
  output logic                    tx_auto_stb_userbit
);

  //////////////////////////////////////////////////
  // Receive side delay
  //////////////////////////////////////////////////

  // Up-counter, stops once delay_x is reached
  logic [delay_width-1:0] rx_cnt;

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online_delay) begin
      if (rx_cnt == delay_x_value) begin
        rx_online_delay <= 1'b1;
      end else begin
        rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Transmit side FSM
  //////////////////////////////////////////////////

  sync_state_t            state, state_nxt;
  // Shared down-counter for y then z
  logic [delay_width-1:0] tx_cnt, tx_cnt_nxt;
  logic                   cnt_done;
  logic                   online_nxt;

  // Last cycle of the current delay
  assign cnt_done = (tx_cnt <= delay_width'(1));

  always_comb begin
    state_nxt  = state;
    tx_cnt_nxt = tx_cnt;
    // Either side going offline restarts the sequence
    if (!tx_online || !rx_online) begin
      state_nxt = sync_idle;
    end else begin
      case (state)
        sync_idle: begin
          if (rx_online_delay) begin
            state_nxt  = sync_wait_y;
            tx_cnt_nxt = delay_y_value;
          end
        end
        sync_wait_y: begin
          if (cnt_done) begin
            state_nxt  = sync_online;
            tx_cnt_nxt = delay_z_value;
          end else begin
            tx_cnt_nxt = tx_cnt - 1'b1;
          end
        end
        // First z cycle, then keep counting in wait_z
        sync_online, sync_wait_z: begin
          if (cnt_done) begin
            state_nxt = sync_strobe;
          end else begin
            state_nxt  = sync_wait_z;
            tx_cnt_nxt = tx_cnt - 1'b1;
          end
        end
        sync_strobe: state_nxt = sync_strobe;
        default:     state_nxt = sync_idle;
      endcase
    end
  end

  // Tx online from entry into sync_online onwards
  assign online_nxt = (state_nxt == sync_online) || (state_nxt == sync_wait_z) ||
                      (state_nxt == sync_strobe);

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      state               <= sync_idle;
      tx_cnt              <= '0;
      tx_online_delay     <= 1'b0;
      tx_auto_mrk_userbit <= '0;
      tx_auto_stb_userbit <= 1'b0;
    end else begin
      state           <= state_nxt;
      tx_cnt          <= tx_cnt_nxt;
      tx_online_delay <= online_nxt;
      // Persistent marker while online, else user bits
      tx_auto_mrk_userbit <= online_nxt ? {marker_width{1'b1}} : tx_mrk_userbit;
      // Persistent strobe after delay_z
      tx_auto_stb_userbit <= (state_nxt == sync_strobe) | tx_stb_userbit;
    end
  end

endmodule

// File: verilog/lpif_pkg.sv
package lpif_pkg;

  //////////////////////////////////////////////////
  // Link geometry
  //////////////////////////////////////////////////

  // One LPIF beat, half-rate layout
  localparam int beat_width   = 150;
  // Raw width of one PHY channel
  localparam int phy_width    = 80;
  // Beat bits carried per channel
  localparam int chan_payload = 75;
  // Programmable auto-sync delays
  localparam int delay_width  = 16;
  // One marker bit per channel
  localparam int marker_width = 2;

  //////////////////////////////////////////////////
  // Beat and channel formats
  //////////////////////////////////////////////////

  // First field sits at the MSB end
  typedef struct packed {
    logic [7:0]   state;
    logic [3:0]   protid;
    logic [127:0] data;
    logic [1:0]   dvalid;
    logic [3:0]   crc;
    logic [1:0]   crc_valid;
    logic [1:0]   valid;
  } lpif_beat_t;

  // Spare bits fill the top of the channel, always zero
  typedef struct packed {
    logic [phy_width-chan_payload-3:0] spare;
    logic                              marker;
    logic                              strobe;
    logic [chan_payload-1:0]           payload;
  } phy_chan_t;

  // Transmit side of auto sync
  typedef enum logic [2:0] {
    sync_idle,
    sync_wait_y,
    sync_online,
    sync_wait_z,
    sync_strobe
  } sync_state_t;

endpackage
